/* rtl/sme_pkg.sv */
package sme_pkg;

	// ------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------
	localparam int STR_MAX = 32;
	localparam int PAT_MAX = 8;
	localparam int BUF_LEN = STR_MAX + 2;   // leading and trailing space slots
	localparam int CHAR_W  = 8;
	localparam int POS_W   = 6;             // covers slots 0 to BUF_LEN-1

	// ------------------------------------------------------------------
	// special characters
	// ------------------------------------------------------------------
	localparam logic [CHAR_W-1:0] CH_SPACE  = 8'h20;
	localparam logic [CHAR_W-1:0] CH_CARET  = 8'h5e;
	localparam logic [CHAR_W-1:0] CH_DOLLAR = 8'h24;
	localparam logic [CHAR_W-1:0] CH_DOT    = 8'h2e;

	typedef logic [CHAR_W-1:0] char_t;

	// window[0] is the char at the start position
	typedef char_t [PAT_MAX-1:0] window_t;

	// ------------------------------------------------------------------
	// pattern storage
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		PAT_LIT = 2'd0,   // exact byte
		PAT_ANY = 2'd1,   // any char inside the string
		PAT_BND = 2'd2    // space or string edge
	} pat_kind_e;

	typedef struct packed {
		pat_kind_e kind;
		char_t     ch;
	} pat_entry_t;

	typedef struct packed {
		pat_entry_t [PAT_MAX-1:0] entry;
		logic [3:0]               len;
		logic                     lead_caret;   // first byte was ^
	} pattern_t;

	typedef struct packed {
		logic       found;
		logic [4:0] index;
	} result_t;

	// ------------------------------------------------------------------
	// controller phases
	// ------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		LOAD_STR = 3'd1,
		WAIT_PAT = 3'd2,
		LOAD_PAT = 3'd3,
		SCAN     = 3'd4,
		REPORT   = 3'd5
	} phase_e;

endpackage

/* rtl/string_buffer.sv */
`timescale 1ns/1ps

module string_buffer import sme_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  char_t            chardata,
	input  logic             isstring,
	input  logic             str_clear,
	input  logic [POS_W-1:0] win_pos,
	output window_t          window,
	output logic [POS_W-1:0] str_len
);

	// slot 0 is the fixed leading space and is not stored
	char_t            mem [1:BUF_LEN-1];
	logic [POS_W-1:0] wr_pos;
	char_t            wr_char;

	assign wr_pos = str_clear ? POS_W'(1) : str_len + POS_W'(1);

	// ^ $ and space all collapse to a space
	always_comb begin
		if (chardata == CH_CARET || chardata == CH_DOLLAR || chardata == CH_SPACE)
			wr_char = CH_SPACE;
		else
			wr_char = chardata;
	end

	always_ff @(posedge clk) begin
		if (isstring && wr_pos <= POS_W'(STR_MAX)) begin
			mem[wr_pos]               <= wr_char;
			mem[wr_pos + POS_W'(1)]   <= CH_SPACE;   // trailing boundary
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			str_len <= '0;
		end else if (isstring) begin
			if (str_clear)
				str_len <= POS_W'(1);
			else if (str_len < POS_W'(STR_MAX))
				str_len <= str_len + POS_W'(1);
		end
	end

	// window read, anything off either end looks like a space
	always_comb begin
		logic [POS_W:0] rd_idx;
		for (int i = 0; i < PAT_MAX; i++) begin
			rd_idx = {1'b0, win_pos} + (POS_W+1)'(i);
			if (rd_idx == '0 || rd_idx >= (POS_W+1)'(BUF_LEN))
				window[i] = CH_SPACE;
			else
				window[i] = mem[rd_idx[POS_W-1:0]];
		end
	end

endmodule

/* rtl/pattern_buffer.sv */
`timescale 1ns/1ps

module pattern_buffer import sme_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  char_t    chardata,
	input  logic     ispattern,
	input  logic     pat_clear,
	output pattern_t pattern
);

	pat_entry_t new_entry;

	// ------------------------------------------------------------------
	// byte classification
	// ------------------------------------------------------------------
	always_comb begin
		new_entry.ch = chardata;
		case (chardata)
			CH_CARET,
			CH_DOLLAR,
			CH_SPACE: new_entry.kind = PAT_BND;
			CH_DOT:   new_entry.kind = PAT_ANY;
			default:  new_entry.kind = PAT_LIT;
		endcase
	end

	// entry store, slot picked by the running length
	always_ff @(posedge clk) begin
		if (ispattern && pattern.len < 4'(PAT_MAX))
			pattern.entry[pattern.len[2:0]] <= new_entry;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pattern.len        <= '0;
			pattern.lead_caret <= 1'b0;
		end else if (pat_clear) begin
			pattern.len        <= '0;
			pattern.lead_caret <= 1'b0;
		end else if (ispattern && pattern.len < 4'(PAT_MAX)) begin
			pattern.len <= pattern.len + 4'd1;
			if (pattern.len == '0)
				pattern.lead_caret <= (chardata == CH_CARET);
		end
	end

endmodule

/* rtl/match_scanner.sv */
`timescale 1ns/1ps

module match_scanner import sme_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             scan_start,
	input  pattern_t         pattern,
	input  window_t          window,
	input  logic [POS_W-1:0] str_len,
	output logic [POS_W-1:0] win_pos,
	output logic             scan_done,
	output result_t          scan_result
);

	logic [POS_W-1:0] pos;
	logic             busy;
	logic             active;
	logic [PAT_MAX-1:0] ent_ok;
	logic [POS_W:0]   span_end;    // pos + len
	logic [POS_W:0]   limit;       // str_len + 2
	logic             in_range;
	logic             at_end;
	logic             hit;
	logic [POS_W-1:0] idx_full;

	// position 0 is tested in the scan_start cycle itself
	assign active  = scan_start | busy;
	assign win_pos = pos;

	// ------------------------------------------------------------------
	// per entry compare, all entries in parallel
	// ------------------------------------------------------------------
	always_comb begin
		logic [POS_W:0] abs_pos;
		for (int i = 0; i < PAT_MAX; i++) begin
			abs_pos = {1'b0, pos} + (POS_W+1)'(i);
			if (4'(i) >= pattern.len) begin
				ent_ok[i] = 1'b1;   // unused entry
			end else begin
				case (pattern.entry[i].kind)
					PAT_BND: ent_ok[i] = (window[i] == CH_SPACE);
					PAT_ANY: ent_ok[i] = (abs_pos >= (POS_W+1)'(1)) &&
						(abs_pos <= {1'b0, str_len});
					default: ent_ok[i] = (window[i] == pattern.entry[i].ch);
				endcase
			end
		end
	end

	assign span_end = {1'b0, pos} + (POS_W+1)'(pattern.len);
	assign limit    = {1'b0, str_len} + (POS_W+1)'(2);
	assign in_range = (span_end <= limit);
	assign at_end   = (span_end >= limit);   // also true if nothing fits at all
	assign hit      = in_range && (&ent_ok);

	assign scan_done = active && (hit || at_end);

	// index of the first real char, ^ skips one slot
	assign idx_full = pos + POS_W'(pattern.lead_caret);

	always_comb begin
		scan_result.found = hit;
		if (!hit || idx_full == '0)
			scan_result.index = '0;
		else
			scan_result.index = 5'(idx_full - POS_W'(1));
	end

	// ------------------------------------------------------------------
	// position stepper
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			pos  <= '0;
		end else if (scan_done) begin
			busy <= 1'b0;
			pos  <= '0;                 // park at 0 for the next search
		end else if (active) begin
			busy <= 1'b1;
			pos  <= pos + POS_W'(1);
		end
	end

endmodule

/* rtl/sme_ctrl.sv */
`timescale 1ns/1ps

module sme_ctrl import sme_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       isstring,
	input  logic       ispattern,
	input  logic       scan_done,
	input  result_t    scan_result,
	output logic       str_clear,
	output logic       pat_clear,
	output logic       scan_start,
	output logic       out_valid,
	output logic       match,
	output logic [4:0] match_index
);

	phase_e state;
	phase_e state_nxt;
	logic   report_now;

	// ------------------------------------------------------------------
	// phase FSM
	// ------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (isstring)
					state_nxt = LOAD_STR;
				else if (ispattern)
					state_nxt = LOAD_PAT;   // reuse the last string
			end
			LOAD_STR: if (!isstring)  state_nxt = WAIT_PAT;
			WAIT_PAT: if (ispattern)  state_nxt = LOAD_PAT;
			LOAD_PAT: if (!ispattern) state_nxt = SCAN;
			SCAN:     if (scan_done)  state_nxt = REPORT;
			REPORT:   state_nxt = IDLE;
			default:  state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// first byte of a fresh string
	assign str_clear = (state == IDLE) && isstring;
	assign pat_clear = (state == REPORT);

	assign report_now = (state == SCAN) && scan_done;

	// ------------------------------------------------------------------
	// strobes and registered result
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scan_start  <= 1'b0;
			out_valid   <= 1'b0;
			match       <= 1'b0;
			match_index <= '0;
		end else begin
			scan_start <= (state == LOAD_PAT) && !ispattern;
			out_valid  <= report_now;
			if (report_now) begin
				match       <= scan_result.found;
				match_index <= scan_result.index;
			end else begin
				match       <= 1'b0;   // quiet outside the pulse
				match_index <= '0;
			end
		end
	end

endmodule

/* rtl/sme.sv */
`timescale 1ns/1ps

module sme import sme_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  char_t      chardata,
	input  logic       isstring,
	input  logic       ispattern,
	output logic       out_valid,
	output logic       match,
	output logic [4:0] match_index
);

	logic             str_clear;
	logic             pat_clear;
	logic             scan_start;
	logic             scan_done;
	result_t          scan_result;
	logic [POS_W-1:0] win_pos;
	logic [POS_W-1:0] str_len;
	window_t          window;
	pattern_t         pattern;

	sme_ctrl i_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.isstring    (isstring),
		.ispattern   (ispattern),
		.scan_done   (scan_done),
		.scan_result (scan_result),
		.str_clear   (str_clear),
		.pat_clear   (pat_clear),
		.scan_start  (scan_start),
		.out_valid   (out_valid),
		.match       (match),
		.match_index (match_index)
	);

	string_buffer i_string_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.chardata  (chardata),
		.isstring  (isstring),
		.str_clear (str_clear),
		.win_pos   (win_pos),
		.window    (window),
		.str_len   (str_len)
	);

	pattern_buffer i_pattern_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.chardata  (chardata),
		.ispattern (ispattern),
		.pat_clear (pat_clear),
		.pattern   (pattern)
	);

	match_scanner i_match_scanner (
		.clk         (clk),
		.rst_n       (rst_n),
		.scan_start  (scan_start),
		.pattern     (pattern),
		.window      (window),
		.str_len     (str_len),
		.win_pos     (win_pos),
		.scan_done   (scan_done),
		.scan_result (scan_result)
	);

endmodule

/* tests/sme_sva.sv */
`timescale 1ns/1ps

module sme_sva (
	input logic       clk,
	input logic       rst_n,
	input logic       out_valid,
	input logic       match,
	input logic [4:0] match_index
);

	int n_fail = 0;   // read by the testbench summary

	// result strobe is a single cycle
	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
	else begin
		n_fail++;
		$error("out_valid stayed high for more than one cycle");
	end

	a_index_no_match: assert property (@(posedge clk) disable iff (!rst_n)
		!match |-> (match_index == '0))
	else begin
		n_fail++;
		$error("match_index is not zero while match is low");
	end

	// quiet outputs between results
	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (!match && match_index == '0))
	else begin
		n_fail++;
		$error("match or match_index set while out_valid is low");
	end

endmodule

bind sme sme_sva i_sme_sva (
	.clk         (clk),
	.rst_n       (rst_n),
	.out_valid   (out_valid),
	.match       (match),
	.match_index (match_index)
);

/* tests/tb_sme.sv */
`timescale 1ns/1ps

module tb_sme import sme_pkg::*; ();

	localparam int    T_HALF      = 2;              // 4 ns clock
	localparam int    RESET_CYC   = 4;
	localparam int    WAIT_LIMIT  = STR_MAX + 4;    // latency bound for a result
	localparam int    CYC_PER_REC = 80;
	localparam string TRACE_FILE  = "tests/sme_trace.txt";

	logic       clk;
	logic       rst_n;
	char_t      chardata;
	logic       isstring;
	logic       ispattern;
	logic       out_valid;
	logic       match;
	logic [4:0] match_index;

	string rec_kind[$];
	string rec_text[$];
	int    rec_match[$];
	int    rec_index[$];
	int    n_tests;
	int    n_passed;
	int    n_errors;
	int    n_pulses;
	logic  trace_ready;

	sme i_sme (
		.clk         (clk),
		.rst_n       (rst_n),
		.chardata    (chardata),
		.isstring    (isstring),
		.ispattern   (ispattern),
		.out_valid   (out_valid),
		.match       (match),
		.match_index (match_index)
	);

	initial begin
		clk = 1'b0;
		forever #T_HALF clk = ~clk;
	end

	// ------------------------------------------------------------------
	// trace reading
	// ------------------------------------------------------------------
	function automatic char_t decode_char(input byte c);
		return (c == "~") ? CH_SPACE : char_t'(c);   // ~ stands for a space
	endfunction

	task automatic load_trace();
		int    fd;
		int    m;
		int    idx;
		logic  ok;
		string tok;
		string txt;
		string rest;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the trace file %s", TRACE_FILE);
			n_errors++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.getc(0) == "#") begin
					ok = ($fgets(rest, fd) > 0);   // rest of a comment line
				end else if (tok == "S" || tok == "P") begin
					m   = 0;
					idx = 0;
					if (tok == "S")
						ok = ($fscanf(fd, "%s", txt) == 1);
					else
						ok = ($fscanf(fd, "%s %d %d", txt, m, idx) == 3);
					if (ok) begin
						rec_kind.push_back(tok);
						rec_text.push_back(txt);
						rec_match.push_back(m);
						rec_index.push_back(idx);
					end else begin
						$display("incomplete %s record in the trace file", tok);
						n_errors++;
					end
				end else begin
					$display("unknown record type %s in the trace file", tok);
					n_errors++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------------------------------------------
	// stimulus, one byte per cycle on the falling edge
	// ------------------------------------------------------------------
	task automatic send_bytes(input string txt, input logic as_pattern);
		for (int i = 0; i < txt.len(); i++) begin
			@(negedge clk);
			chardata  = decode_char(txt.getc(i));
			isstring  = !as_pattern;
			ispattern = as_pattern;
		end
		@(negedge clk);
		chardata  = '0;
		isstring  = 1'b0;
		ispattern = 1'b0;
	endtask

	task automatic run_test(input int t, input int r);
		int         waited;
		int         errs_before;
		logic       seen;
		logic       got_match;
		logic [4:0] got_index;
		errs_before = n_errors;
		waited      = 0;
		seen        = 1'b0;
		got_match   = 1'b0;
		got_index   = '0;
		send_bytes(rec_text[r], 1'b1);
		while (!seen && waited < WAIT_LIMIT + 4) begin
			@(negedge clk);
			waited++;
			if (out_valid) begin
				seen      = 1'b1;
				got_match = match;
				got_index = match_index;
			end
		end
		assert (seen) else begin
			$display("test %0d got no out_valid within %0d cycles", t, waited);
			n_errors++;
		end
		if (seen) begin
			assert (waited >= 2 && waited <= WAIT_LIMIT) else begin
				$display("error at %0t: test %0d result after %0d cycles, allowed 2 to %0d",
					$time, t, waited, WAIT_LIMIT);
				n_errors++;
			end
			assert (int'(got_match) == rec_match[r] && int'(got_index) == rec_index[r])
			else begin
				$display("error at %0t: test %0d pattern %s expected match %0d index %0d",
					$time, t, rec_text[r], rec_match[r], rec_index[r]);
				$display("    got match %0d index %0d", got_match, got_index);
				n_errors++;
			end
		end
		if (n_errors == errs_before)
			n_passed++;
		$display("test %0d  pattern %s  match %0d index %0d  %s", t, rec_text[r],
			got_match, got_index, (n_errors == errs_before) ? "ok" : "bad");
	endtask

	// every pulse counts, including ones nobody asked for
	always @(negedge clk) begin
		if (rst_n && out_valid)
			n_pulses++;
	end

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		rst_n       = 1'b0;
		chardata    = '0;
		isstring    = 1'b0;
		ispattern   = 1'b0;
		n_tests     = 0;
		n_passed    = 0;
		n_errors    = 0;
		n_pulses    = 0;
		trace_ready = 1'b0;
		load_trace();
		trace_ready = 1'b1;
		repeat (RESET_CYC) @(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < rec_kind.size(); r++) begin
			if (rec_kind[r] == "S") begin
				send_bytes(rec_text[r], 1'b0);
			end else begin
				n_tests++;
				run_test(n_tests, r);
			end
		end
		repeat (4) @(negedge clk);
		assert (n_pulses == n_tests) else begin
			$display("saw %0d out_valid pulses for %0d patterns", n_pulses, n_tests);
			n_errors++;
		end
		assert (i_sme.i_sme_sva.n_fail == 0) else begin
			$display("%0d bound assertion failures", i_sme.i_sme_sva.n_fail);
			n_errors++;
		end
		$display("%0d tests, %0d passed, %0d errors", n_tests, n_passed, n_errors);
		if (n_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog, scaled by the trace length, one spare record covers reset and drain
	initial begin
		wait (trace_ready);
		repeat ((rec_kind.size() + 1) * CYC_PER_REC) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles",
			(rec_kind.size() + 1) * CYC_PER_REC);
		$display("Test failed");
		$finish;
	end

endmodule

/* tests/sme_trace.txt */
# S <string>  or  P <pattern> <expected match> <expected index>
# ~ stands for a space, fields are split by white space
S hello~world
P world 1 6
P lo 1 3
P xyz 0 0
P ^hello 1 0
P ^world 1 6
P world$ 1 6
P hello$ 1 0
P o$ 1 4
P $ 1 0
P l.o 1 2
P o.w 1 4
P d. 0 0
P .h 0 0
S abcabcab
P cab 1 2
P ab$ 1 6
S the~quick~brown~fox~jumps~over~a
P a$ 1 31
P ^fox 1 16
P o..r 1 26
P dog 0 0
S xy
P y$ 1 1
P y. 0 0
P ye 0 0
P ^xy$ 1 0
P xyzw 0 0

/* vlog.f */
rtl/sme_pkg.sv
rtl/string_buffer.sv
rtl/pattern_buffer.sv
rtl/match_scanner.sv
rtl/sme_ctrl.sv
rtl/sme.sv
tests/sme_sva.sv
tests/tb_sme.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
LINTFLAGS := --lint-only -Wall
TOP       := tb_sme
FILELIST  := vlog.f
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
